// ==== design/uart_pkg.sv ====
// shared definitions for the uart transmit subsystem
// bus request struct carried by both masters and the arbiter
// register map of the transmitter
// divider value after reset
`default_nettype none

package uart_pkg;

   // one register access, held stable by the master until ack
   typedef struct packed {
      logic [1:0]  addr;   // register index
      logic        sel;    // access strobe
      logic        we;     // 1 = write, 0 = read
      logic [31:0] wdata;  // write word
   } bus_req_t;

   // register map, one 32-bit word each
   localparam logic [1:0] REG_WAIT  = 2'd0;  // busy status, read only
   localparam logic [1:0] REG_DIV   = 2'd1;  // clocks per serial bit
   localparam logic [1:0] REG_DATA  = 2'd2;  // write starts a frame
   localparam logic [1:0] REG_RESET = 2'd3;  // write pulses soft reset

   // divider after hard or soft reset
   // one clock per bit, fastest line rate
   localparam logic [31:0] DIV_RESET = 32'd1;

endpackage

`default_nettype wire

// ==== design/bus_arbiter.sv ====
// fixed priority arbiter for the transmitter register port
// host wins whenever its sel is high, feeder gets idle cycles
// parked copy of the feeder request across host interruptions
`timescale 1ns/100ps
`default_nettype none

module bus_arbiter (
   input  wire               clk,
   input  wire               rstn_int,
   input  uart_pkg::bus_req_t host_req,
   input  uart_pkg::bus_req_t feed_req,
   output logic              host_ack,
   output logic              feed_ack,
   output uart_pkg::bus_req_t reg_req
);

   logic               feed_parked;  // feeder waiting behind host
   uart_pkg::bus_req_t feed_held;    // feeder request seen when parked
   uart_pkg::bus_req_t feed_fwd;     // feeder request as forwarded

   // acks are combinational, same cycle as the grant
   assign host_ack = host_req.sel;
   assign feed_ack = feed_req.sel & ~host_req.sel;  // only when host idle

   // set when the host takes the port from a requesting feeder,
   // cleared once the feeder finally gets its grant
   always_ff @(posedge clk or negedge rstn_int) begin
      if (!rstn_int) begin
         feed_parked <= 1'b0;
      end else if (feed_ack) begin
         feed_parked <= 1'b0;
      end else if (host_ack && feed_req.sel) begin
         feed_parked <= 1'b1;
      end
   end

   // capture on the first interrupted cycle only
   always_ff @(posedge clk) begin
      if (host_ack && feed_req.sel && !feed_parked) begin
         feed_held <= feed_req;
      end
   end

   // while parked, address/we/data come from the held copy
   always_comb begin
      feed_fwd = feed_req;
      if (feed_parked) begin
         feed_fwd.addr  = feed_held.addr;
         feed_fwd.we    = feed_held.we;
         feed_fwd.wdata = feed_held.wdata;
      end
   end

   // winner mux, sel low when nobody asks
   always_comb begin
      reg_req = '0;
      if (host_req.sel) begin
         reg_req = host_req;
      end else if (feed_req.sel) begin
         reg_req = feed_fwd;
      end
   end

endmodule

`default_nettype wire

// ==== design/uart_tx_regs.sv ====
// uart transmitter with its register port
// write decoder, read mux and soft reset
// divider register, bit timing counter and bit counter
// 10-bit shift register, start bit first, lsb first, stop bit last
`timescale 1ns/100ps
`default_nettype none

module uart_tx_regs #(
   parameter int DIV_W = 16  // divider and divider counter width
) (
   input  wire               clk,
   input  wire               rstn_int,
   input  uart_pkg::bus_req_t reg_req,
   output logic [31:0]       rdata,
   output logic              ser_tx
);

   logic             div_wr;     // write to DIV
   logic             dat_wr;     // write to DATA, starts a frame
   logic             rstn_soft;  // low during a RESET write
   logic             regs_rstn;  // hard and soft reset combined
   logic [DIV_W-1:0] div_q;      // clocks per bit
   logic [DIV_W-1:0] div_cnt;    // position inside the current bit
   logic [3:0]       bit_cnt;    // bits left in the frame
   logic [9:0]       shift_q;    // frame pattern, bit 0 on the line
   logic             busy;
   logic             bit_tick;   // last clock of the current bit

   // write decoder
   always_comb begin
      div_wr    = 1'b0;
      dat_wr    = 1'b0;
      rstn_soft = 1'b1;
      if (reg_req.sel && reg_req.we) begin
         case (reg_req.addr)
            uart_pkg::REG_DIV:   div_wr = 1'b1;
            uart_pkg::REG_DATA:  dat_wr = 1'b1;
            uart_pkg::REG_RESET: rstn_soft = 1'b0;  // held for the ack cycle
            default: ;                              // WAIT is read only
         endcase
      end
   end

   assign regs_rstn = rstn_int & rstn_soft;

   assign busy     = (bit_cnt != 4'd0);
   assign bit_tick = busy && (div_q != '0) && (div_cnt == div_q);  // div 0 stalls

   // read mux, DATA and RESET have no readable content
   always_comb begin
      case (reg_req.addr)
         uart_pkg::REG_WAIT: rdata = {31'd0, busy};
         uart_pkg::REG_DIV:  rdata = {{(32-DIV_W){1'b0}}, div_q};  // zero extended
         default:            rdata = '1;
      endcase
   end

   // divider register
   always_ff @(posedge clk or negedge regs_rstn) begin
      if (!regs_rstn) begin
         div_q <= uart_pkg::DIV_RESET[DIV_W-1:0];
      end else if (div_wr) begin
         div_q <= reg_req.wdata[DIV_W-1:0];
      end
   end

   // counts 1..div_q inside each bit, parked at 0 when idle
   always_ff @(posedge clk or negedge regs_rstn) begin
      if (!regs_rstn) begin
         div_cnt <= '0;
      end else if (dat_wr) begin
         div_cnt <= DIV_W'(1);      // first clock of the start bit
      end else if (bit_tick) begin
         div_cnt <= busy && (bit_cnt != 4'd1) ? DIV_W'(1) : '0;  // next bit or stop
      end else if (busy) begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   // bits remaining, WAIT reads this as nonzero
   always_ff @(posedge clk or negedge regs_rstn) begin
      if (!regs_rstn) begin
         bit_cnt <= 4'd0;
      end else if (dat_wr) begin
         bit_cnt <= 4'd10;          // start + 8 data + stop
      end else if (bit_tick) begin
         bit_cnt <= bit_cnt - 1'b1;
      end
   end

   // shift right, ones fill in behind the stop bit
   always_ff @(posedge clk or negedge regs_rstn) begin
      if (!regs_rstn) begin
         shift_q <= '1;             // idle line high
      end else if (dat_wr) begin
         shift_q <= {1'b1, reg_req.wdata[7:0], 1'b0};
      end else if (bit_tick) begin
         shift_q <= {1'b1, shift_q[9:1]};
      end
   end

   assign ser_tx = shift_q[0];

endmodule

`default_nettype wire

// ==== design/tx_byte_feeder.sv ====
// byte feeder, second bus master of the transmitter
// circular byte queue filled through push/push_data
// poll/write FSM: read WAIT until idle, then write DATA with the head
`timescale 1ns/100ps
`default_nettype none

module tx_byte_feeder #(
   parameter int QUEUE_DEPTH = 16  // power of two
) (
   input  wire                clk,
   input  wire                rstn_int,
   input  wire                push,
   input  wire  [7:0]         push_data,
   output logic               queue_full,
   output uart_pkg::bus_req_t feed_req,
   input  wire                feed_ack,
   input  wire  [31:0]        rdata
);

   localparam int AW = $clog2(QUEUE_DEPTH);  // queue index width

   typedef enum logic {
      ST_POLL,   // reading WAIT
      ST_WRITE   // writing the head byte to DATA
   } fsm_t;

   fsm_t        state;
   logic [7:0]  mem [QUEUE_DEPTH];  // queue storage
   logic [AW:0] wr_ptr;             // extra msb tells full from empty
   logic [AW:0] rd_ptr;
   logic        queue_empty;
   logic        push_ok;            // accepted push
   logic        pop;                // head consumed by a DATA write
   logic [7:0]  head_byte;

   assign queue_empty = (wr_ptr == rd_ptr);
   assign queue_full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                        (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
   assign push_ok     = push & ~queue_full;  // pushes while full are lost
   assign pop         = (state == ST_WRITE) & feed_ack;
   assign head_byte   = mem[rd_ptr[AW-1:0]];

   // queue storage
   always_ff @(posedge clk) begin
      if (push_ok) begin
         mem[wr_ptr[AW-1:0]] <= push_data;
      end
   end

   // pointers wrap naturally at the power of two
   always_ff @(posedge clk or negedge rstn_int) begin
      if (!rstn_int) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push_ok) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   // poll until the transmitter reports idle, then send one byte
   always_ff @(posedge clk or negedge rstn_int) begin
      if (!rstn_int) begin
         state <= ST_POLL;
      end else begin
         case (state)
            ST_POLL: begin
               if (feed_ack && (rdata == 32'd0)) begin
                  state <= ST_WRITE;  // line idle
               end
            end
            ST_WRITE: begin
               if (feed_ack) begin
                  state <= ST_POLL;   // byte handed over
               end
            end
            default: state <= ST_POLL;
         endcase
      end
   end

   // request stays stable until acked
   always_comb begin
      feed_req = '0;
      case (state)
         ST_POLL: begin
            feed_req.sel  = ~queue_empty;  // poll only with data waiting
            feed_req.addr = uart_pkg::REG_WAIT;
         end
         ST_WRITE: begin
            feed_req.sel   = 1'b1;         // queue never empty here
            feed_req.addr  = uart_pkg::REG_DATA;
            feed_req.we    = 1'b1;
            feed_req.wdata = {24'd0, head_byte};
         end
         default: ;
      endcase
   end

endmodule

`default_nettype wire

// ==== design/uart_subsys_top.sv ====
// uart transmit subsystem top level
// host and byte feeder share the register port via the arbiter
// read data fans out to both masters
`timescale 1ns/100ps
`default_nettype none

module uart_subsys_top #(
   parameter int DIV_W       = 16,  // divider width
   parameter int QUEUE_DEPTH = 16   // feeder queue depth, power of two
) (
   input  wire                clk,
   input  wire                rstn_int,
   input  uart_pkg::bus_req_t host_req,   // external master
   output logic               host_ack,
   output logic [31:0]        rdata,      // valid while an ack is high
   input  wire                push,       // one byte into the queue
   input  wire  [7:0]         push_data,
   output logic               queue_full,
   output logic               ser_tx      // serial line, idle high
);

   uart_pkg::bus_req_t feed_req;  // feeder to arbiter
   uart_pkg::bus_req_t reg_req;   // arbiter to transmitter
   logic               feed_ack;

   bus_arbiter u_arb (
      .clk      (clk),
      .rstn_int (rstn_int),
      .host_req (host_req),
      .feed_req (feed_req),
      .host_ack (host_ack),
      .feed_ack (feed_ack),
      .reg_req  (reg_req)
   );

   uart_tx_regs #(
      .DIV_W (DIV_W)
   ) u_tx (
      .clk      (clk),
      .rstn_int (rstn_int),
      .reg_req  (reg_req),
      .rdata    (rdata),
      .ser_tx   (ser_tx)
   );

   // internal master draining the byte queue
   tx_byte_feeder #(
      .QUEUE_DEPTH (QUEUE_DEPTH)
   ) u_feed (
      .clk        (clk),
      .rstn_int   (rstn_int),
      .push       (push),
      .push_data  (push_data),
      .queue_full (queue_full),
      .feed_req   (feed_req),
      .feed_ack   (feed_ack),
      .rdata      (rdata)     // shared read bus
   );

endmodule

`default_nettype wire

// ==== test/tb_uart_subsys.sv ====
// testbench for the uart transmit subsystem
// stimulus table applied in a loop, host bus task
// serial frame decoder running beside the table
// watchdog on a cycle budget derived from the table
`timescale 1ns/100ps
`default_nettype none

module tb_uart_subsys;

   localparam logic [2:0] OP_READ   = 3'd0;  // host read, exp is the read word
   localparam logic [2:0] OP_WRITE  = 3'd1;  // host write of data
   localparam logic [2:0] OP_PUSH   = 3'd2;  // push data bytes, exp is the trailing drop count
   localparam logic [2:0] OP_FRAMES = 3'd3;  // wait until data frames decoded
   localparam logic [2:0] OP_MID    = 3'd4;  // wait for a start bit plus data cycles
   localparam logic [2:0] OP_LINE   = 3'd5;  // ser_tx against exp

   typedef struct packed {
      logic [2:0]  op;
      logic [2:0]  test;  // behavior number 1..6
      logic [1:0]  addr;
      logic [31:0] data;
      logic [31:0] exp;
   } row_t;

   logic               clk = 1'b0;
   logic               rstn_int;
   uart_pkg::bus_req_t host_req;
   logic               host_ack;
   logic [31:0]        rdata;
   logic               push;
   logic [7:0]         push_data;
   logic               queue_full;
   logic               ser_tx;

   row_t        rows[$];
   logic [7:0]  exp_q[$];          // bytes due on the line, push order
   logic [31:0] rng = 32'h2a0f;    // xorshift state
   int unsigned tb_div = 1;        // divider last written
   int unsigned table_div = 1;     // divider tracked while the table is built
   int unsigned limit = 1000;      // cycle budget, grows per row
   int unsigned cycles = 0;
   int unsigned errors = 0;
   int unsigned frames_done = 0;
   logic        in_frame = 1'b0;   // decoder inside a frame
   logic        abort_req = 1'b0;  // soft reset cuts the frame in flight

   uart_subsys_top #(
      .DIV_W       (16),
      .QUEUE_DEPTH (16)
   ) u_dut (
      .clk        (clk),
      .rstn_int   (rstn_int),
      .host_req   (host_req),
      .host_ack   (host_ack),
      .rdata      (rdata),
      .push       (push),
      .push_data  (push_data),
      .queue_full (queue_full),
      .ser_tx     (ser_tx)
   );

   always #50 clk = ~clk;  // 100 ns period

   // run limit
   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles > limit) begin
         $display("timeout after %0d cycles, DUT stopped making progress", cycles);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   task automatic show_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] want);
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, want);
      errors++;
   endtask

   function automatic logic [7:0] next_byte();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng[7:0];
   endfunction

   function automatic string reg_name(input logic [1:0] addr);
      case (addr)
         uart_pkg::REG_WAIT: return "rdata WAIT";
         uart_pkg::REG_DIV:  return "rdata DIV";
         uart_pkg::REG_DATA: return "rdata DATA";
         default:            return "rdata RESET";
      endcase
   endfunction

   function automatic string test_title(input int unsigned id);
      case (id)
         1:       return "reset values";
         2:       return "host divider and single frame";
         3:       return "queued bytes in order";
         4:       return "full queue drops a push";
         5:       return "host reads during feeder traffic";
         6:       return "soft reset mid frame";
         default: return "unknown";
      endcase
   endfunction

   // one row, budget follows the frame lengths
   task automatic add_row(input logic [2:0] op, input int unsigned test, input logic [1:0] addr,
                          input logic [31:0] data, input logic [31:0] exp);
      row_t r;
      r.op   = op;
      r.test = test[2:0];
      r.addr = addr;
      r.data = data;
      r.exp  = exp;
      rows.push_back(r);
      if (op == OP_WRITE && addr == uart_pkg::REG_DIV) table_div = data;
      if (op == OP_WRITE && addr == uart_pkg::REG_RESET) table_div = 1;
      if (op == OP_FRAMES) limit += data * (10 * table_div + 20);
      if (op == OP_MID) limit += 10 * table_div + data;
      if (op == OP_PUSH) limit += data;
      limit += 40;
   endtask

   task automatic build_table();
      add_row(OP_LINE,   1, 2'd0,                32'd0,     32'd1);
      add_row(OP_READ,   1, uart_pkg::REG_WAIT,  32'd0,     32'd0);
      add_row(OP_READ,   1, uart_pkg::REG_DIV,   32'd0,     32'd1);
      add_row(OP_READ,   1, uart_pkg::REG_DATA,  32'd0,     32'hffff_ffff);
      add_row(OP_READ,   1, uart_pkg::REG_RESET, 32'd0,     32'hffff_ffff);
      add_row(OP_WRITE,  2, uart_pkg::REG_DIV,   32'd4,     32'd0);
      add_row(OP_READ,   2, uart_pkg::REG_DIV,   32'd0,     32'd4);
      add_row(OP_WRITE,  2, uart_pkg::REG_DATA,  32'h0000_00a5, 32'd0);
      add_row(OP_READ,   2, uart_pkg::REG_WAIT,  32'd0,     32'd1);  // frame running
      add_row(OP_FRAMES, 2, 2'd0,                32'd1,     32'd0);
      add_row(OP_READ,   2, uart_pkg::REG_WAIT,  32'd0,     32'd0);
      add_row(OP_PUSH,   3, 2'd0,                32'd8,     32'd0);
      add_row(OP_FRAMES, 3, 2'd0,                32'd8,     32'd0);
      add_row(OP_WRITE,  4, uart_pkg::REG_DIV,   32'd200,   32'd0);
      add_row(OP_PUSH,   4, 2'd0,                32'd18,    32'd1);  // 1 sent, 16 queued
      add_row(OP_FRAMES, 4, 2'd0,                32'd17,    32'd0);
      add_row(OP_WRITE,  5, uart_pkg::REG_DIV,   32'd8,     32'd0);
      add_row(OP_PUSH,   5, 2'd0,                32'd6,     32'd0);
      add_row(OP_READ,   5, uart_pkg::REG_DIV,   32'd0,     32'd8);
      add_row(OP_READ,   5, uart_pkg::REG_DIV,   32'd0,     32'd8);
      add_row(OP_FRAMES, 5, 2'd0,                32'd2,     32'd0);
      add_row(OP_READ,   5, uart_pkg::REG_DIV,   32'd0,     32'd8);
      add_row(OP_FRAMES, 5, 2'd0,                32'd4,     32'd0);
      add_row(OP_WRITE,  6, uart_pkg::REG_DIV,   32'd50,    32'd0);
      add_row(OP_PUSH,   6, 2'd0,                32'd5,     32'd0);
      add_row(OP_MID,    6, 2'd0,                32'd150,   32'd0);  // three bits in
      add_row(OP_WRITE,  6, uart_pkg::REG_RESET, 32'd0,     32'd0);
      add_row(OP_LINE,   6, 2'd0,                32'd0,     32'd1);
      add_row(OP_READ,   6, uart_pkg::REG_WAIT,  32'd0,     32'd0);
      add_row(OP_READ,   6, uart_pkg::REG_DIV,   32'd0,     32'd1);
      add_row(OP_FRAMES, 6, 2'd0,                32'd4,     32'd0);  // rest at divider 1
   endtask

   // called just after a falling edge, returns at a falling edge with sel low
   task automatic host_access(input logic we, input logic [1:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rd);
      host_req.addr  = addr;
      host_req.we    = we;
      host_req.wdata = wdata;
      host_req.sel   = 1'b1;
      #1;
      if (!host_ack) begin
         $display("host request at %0t was not acked in its first cycle", $time);
         errors++;
      end
      while (!host_ack) begin
         @(negedge clk);
         #1;
      end
      rd = rdata;
      @(posedge clk);  // write lands here
      @(negedge clk);
      host_req = '0;
   endtask

   // serial decoder, mid-bit samples with the divider in force at the start bit
   initial begin : frame_decoder
      logic [9:0]  bits;
      logic [7:0]  want;
      int unsigned d;
      int unsigned gap;
      logic        cut;
      forever begin
         @(negedge clk);
         if (rstn_int === 1'b1 && ser_tx === 1'b0) begin
            in_frame = 1'b1;
            cut      = 1'b0;
            d        = tb_div;
            for (int k = 0; k < 10; k++) begin
               gap = (k == 0) ? (d - 1) / 2 : d;  // already half a clock into start
               while (gap > 0 && !abort_req) begin
                  @(negedge clk);
                  gap--;
               end
               if (abort_req) begin
                  cut = 1'b1;
                  break;
               end
               bits[k] = ser_tx;
            end
            if (cut) begin
               abort_req = 1'b0;
               if (exp_q.size() > 0) want = exp_q.pop_front();  // byte lost to the reset
            end else begin
               if (bits[0] !== 1'b0) show_mismatch("ser_tx start bit", bits[0], 32'd0);
               if (bits[9] !== 1'b1) show_mismatch("ser_tx stop bit", bits[9], 32'd1);
               if (exp_q.size() == 0) begin
                  $display("frame with byte %h at %0t was not expected", bits[8:1], $time);
                  errors++;
               end else begin
                  want = exp_q.pop_front();
                  if (bits[8:1] !== want) show_mismatch("ser_tx byte", bits[8:1], want);
               end
               frames_done++;
            end
            in_frame = 1'b0;
         end
      end
   end

   initial begin : main
      row_t        r;
      logic [31:0] got;
      logic [7:0]  b;
      logic        full_exp;
      int unsigned target;
      int unsigned cur_test;
      int unsigned err0;
      int unsigned tests_run;
      rstn_int  = 1'b0;
      host_req  = '0;
      push      = 1'b0;
      push_data = 8'd0;
      cur_test  = 0;
      err0      = 0;
      tests_run = 0;
      build_table();
      repeat (10) @(posedge clk);
      @(negedge clk);
      rstn_int = 1'b1;
      foreach (rows[i]) begin
         r = rows[i];
         if (r.test != cur_test) begin
            if (cur_test != 0) begin
               $display("test %0d %s: %s, %0d errors", cur_test, test_title(cur_test),
                        (errors == err0) ? "pass" : "fail", errors - err0);
            end
            cur_test = r.test;
            err0     = errors;
            tests_run++;
         end
         case (r.op)
            OP_READ: begin
               host_access(1'b0, r.addr, 32'd0, got);
               if (got !== r.exp) show_mismatch(reg_name(r.addr), got, r.exp);
            end
            OP_WRITE: begin
               if (r.addr == uart_pkg::REG_DIV) tb_div = r.data;
               if (r.addr == uart_pkg::REG_DATA) exp_q.push_back(r.data[7:0]);
               if (r.addr == uart_pkg::REG_RESET) begin
                  abort_req = in_frame;
                  tb_div    = 1;
               end
               host_access(1'b1, r.addr, r.data, got);
            end
            OP_PUSH: begin
               for (int n = 0; n < r.data; n++) begin
                  b         = next_byte();
                  full_exp  = (n >= r.data - r.exp);  // only the last exp pushes see full
                  push      = 1'b1;
                  push_data = b;
                  if (queue_full !== full_exp) show_mismatch("queue_full", queue_full, full_exp);
                  if (!full_exp) exp_q.push_back(b);  // accepted, due on the line
                  @(negedge clk);
               end
               push = 1'b0;
            end
            OP_FRAMES: begin
               target = frames_done + r.data;
               while (frames_done < target) @(negedge clk);
               repeat (tb_div) @(negedge clk);  // past the end of the stop bit
            end
            OP_MID: begin
               while (!in_frame) @(negedge clk);
               repeat (r.data) @(negedge clk);
            end
            OP_LINE: begin
               if (ser_tx !== r.exp[0]) show_mismatch("ser_tx", ser_tx, r.exp);
            end
            default: begin
               $display("table row %0d holds an unknown operation", i);
               errors++;
            end
         endcase
      end
      $display("test %0d %s: %s, %0d errors", cur_test, test_title(cur_test),
               (errors == err0) ? "pass" : "fail", errors - err0);
      if (exp_q.size() != 0) begin
         $display("%0d expected bytes never appeared on ser_tx", exp_q.size());
         errors++;
      end
      $display("%0d tests, %0d frames decoded, %0d errors", tests_run, frames_done, errors);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== all.f ====
design/uart_pkg.sv
design/bus_arbiter.sv
design/uart_tx_regs.sv
design/tx_byte_feeder.sv
design/uart_subsys_top.sv
test/tb_uart_subsys.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the uart subsystem testbench with Verilator
# exit status 0 only when the log holds no failure report

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_uart_subsys

verilator --binary --timing -Wno-fatal -f all.f --top-module "$TOP" -o "$TOP"
if [ $? -ne 0 ]; then
   echo "run.sh: verilator build failed"
   exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if [ $sim_status -ne 0 ]; then
   echo "run.sh: simulation exited with status $sim_status"
   exit 1
fi

if grep -F -q "*** TEST FAILED ***" "$LOG"; then
   echo "run.sh: failure found in $LOG"
   exit 1
fi

if ! grep -F -q "*** TEST PASSED ***" "$LOG"; then
   echo "run.sh: simulation ended without a result line"
   exit 1
fi

echo "run.sh: done"
exit 0
